/* issue.f */
+incdir+.
issue_pkg.sv
operand_table.sv
issue_queue.sv
issue.sv
tb_clock_gen.sv
tb_issue.sv

/* issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_params.svh"

module issue (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        disp_req,
    input  wire issue_pkg::unit_type_t disp_type,
    input  wire [`ISSUE_TAG_W-1:0]     disp_dst,
    input  wire [`ISSUE_TAG_W-1:0]     disp_src1,
    input  wire [`ISSUE_TAG_W-1:0]     disp_src2,
    input  wire [`ISSUE_DATA_W-1:0]    disp_imm,
    input  wire [`ISSUE_CTL_W-1:0]     disp_ctl,
    output logic                       disp_ack,
    input  wire                        wake_valid,
    input  wire [`ISSUE_TAG_W-1:0]     wake_tag,
    input  wire [`ISSUE_DATA_W-1:0]    wake_data,
    output logic                       alu_req,
    output logic [`ISSUE_DATA_W-1:0]   alu_src1,
    output logic [`ISSUE_DATA_W-1:0]   alu_src2,
    output logic [`ISSUE_TAG_W-1:0]    alu_dst,
    output logic [`ISSUE_DATA_W-1:0]   alu_imm,
    output logic [`ISSUE_CTL_W-1:0]    alu_ctl,
    input  wire                        alu_ack,
    output logic                       mem_req,
    output logic [`ISSUE_DATA_W-1:0]   mem_src1,
    output logic [`ISSUE_DATA_W-1:0]   mem_src2,
    output logic [`ISSUE_TAG_W-1:0]    mem_dst,
    output logic [`ISSUE_DATA_W-1:0]   mem_imm,
    output logic [`ISSUE_CTL_W-1:0]    mem_ctl,
    input  wire                        mem_ack,
    output logic                       br_req,
    output logic [`ISSUE_DATA_W-1:0]   br_src1,
    output logic [`ISSUE_DATA_W-1:0]   br_src2,
    output logic [`ISSUE_TAG_W-1:0]    br_dst,
    output logic [`ISSUE_DATA_W-1:0]   br_imm,
    output logic [`ISSUE_CTL_W-1:0]    br_ctl,
    input  wire                        br_ack,
    output logic                       mul_req,
    output logic [`ISSUE_DATA_W-1:0]   mul_src1,
    output logic [`ISSUE_DATA_W-1:0]   mul_src2,
    output logic [`ISSUE_TAG_W-1:0]    mul_dst,
    output logic [`ISSUE_DATA_W-1:0]   mul_imm,
    output logic [`ISSUE_CTL_W-1:0]    mul_ctl,
    input  wire                        mul_ack
);

    import issue_pkg::*;

    logic                     rd1_ready;
    logic [`ISSUE_DATA_W-1:0] rd1_value;
    logic                     rd2_ready;
    logic [`ISSUE_DATA_W-1:0] rd2_value;
    operand_t                 src1_op;
    operand_t                 src2_op;
    logic [3:0]               q_sel;
    logic [3:0]               q_full;
    logic [3:0]               q_wr;
    logic                     accept;

    // queue order is alu, mem, branch, mult.
    always_comb begin
        case (disp_type)
            ALU:     q_sel = 4'b0001;
            MEM:     q_sel = 4'b0010;
            BRANCH:  q_sel = 4'b0100;
            MULT:    q_sel = 4'b1000;
            default: q_sel = 4'b0000;
        endcase
    end

    assign accept = disp_req && !disp_ack && ((q_full & q_sel) == 4'b0000);
    assign q_wr   = accept ? q_sel : 4'b0000;

    // ack held until req falls.
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_ack <= 1'b0;
        end else if (accept) begin
            disp_ack <= 1'b1;
        end else if (!disp_req) begin
            disp_ack <= 1'b0;
        end
    end

    operand_table u_table (
        .clk, .rst, .wake_valid, .wake_tag, .wake_data,
        .rd1_tag(disp_src1), .rd2_tag(disp_src2),
        .alloc_valid(accept), .alloc_tag(disp_dst),
        .rd1_ready, .rd1_value, .rd2_ready, .rd2_value
    );

    // value when ready, producer tag otherwise.
    always_comb begin
        src1_op = '0;
        src2_op = '0;
        if (rd1_ready) begin
            src1_op.value = rd1_value;
        end else begin
            src1_op.pend.tag = disp_src1;
        end
        if (rd2_ready) begin
            src2_op.value = rd2_value;
        end else begin
            src2_op.pend.tag = disp_src2;
        end
    end

    issue_queue #(.DEPTH(`ISSUE_ALU_DEPTH)) u_alu_queue (
        .clk, .rst, .wr_valid(q_wr[0]),
        .wr_src1_ready(rd1_ready), .wr_src1(src1_op),
        .wr_src2_ready(rd2_ready), .wr_src2(src2_op),
        .wr_dst(disp_dst), .wr_imm(disp_imm), .wr_ctl(disp_ctl),
        .wake_valid, .wake_tag, .wake_data, .iss_ack(alu_ack), .full(q_full[0]),
        .iss_req(alu_req), .iss_src1(alu_src1), .iss_src2(alu_src2),
        .iss_dst(alu_dst), .iss_imm(alu_imm), .iss_ctl(alu_ctl)
    );

    issue_queue #(.DEPTH(`ISSUE_MEM_DEPTH)) u_mem_queue (
        .clk, .rst, .wr_valid(q_wr[1]),
        .wr_src1_ready(rd1_ready), .wr_src1(src1_op),
        .wr_src2_ready(rd2_ready), .wr_src2(src2_op),
        .wr_dst(disp_dst), .wr_imm(disp_imm), .wr_ctl(disp_ctl),
        .wake_valid, .wake_tag, .wake_data, .iss_ack(mem_ack), .full(q_full[1]),
        .iss_req(mem_req), .iss_src1(mem_src1), .iss_src2(mem_src2),
        .iss_dst(mem_dst), .iss_imm(mem_imm), .iss_ctl(mem_ctl)
    );

    issue_queue #(.DEPTH(`ISSUE_BRANCH_DEPTH)) u_br_queue (
        .clk, .rst, .wr_valid(q_wr[2]),
        .wr_src1_ready(rd1_ready), .wr_src1(src1_op),
        .wr_src2_ready(rd2_ready), .wr_src2(src2_op),
        .wr_dst(disp_dst), .wr_imm(disp_imm), .wr_ctl(disp_ctl),
        .wake_valid, .wake_tag, .wake_data, .iss_ack(br_ack), .full(q_full[2]),
        .iss_req(br_req), .iss_src1(br_src1), .iss_src2(br_src2),
        .iss_dst(br_dst), .iss_imm(br_imm), .iss_ctl(br_ctl)
    );

    issue_queue #(.DEPTH(`ISSUE_MULT_DEPTH)) u_mul_queue (
        .clk, .rst, .wr_valid(q_wr[3]),
        .wr_src1_ready(rd1_ready), .wr_src1(src1_op),
        .wr_src2_ready(rd2_ready), .wr_src2(src2_op),
        .wr_dst(disp_dst), .wr_imm(disp_imm), .wr_ctl(disp_ctl),
        .wake_valid, .wake_tag, .wake_data, .iss_ack(mul_ack), .full(q_full[3]),
        .iss_req(mul_req), .iss_src1(mul_src1), .iss_src2(mul_src2),
        .iss_dst(mul_dst), .iss_imm(mul_imm), .iss_ctl(mul_ctl)
    );

endmodule

`default_nettype wire

/* issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// operand and immediate width.
`define ISSUE_DATA_W 32

// physical register file size.
`define ISSUE_PREG_NUM 32

// tag width covers all physical registers.
`define ISSUE_TAG_W 5

// control field is opaque to the issue stage.
`define ISSUE_CTL_W 8

// queue lengths per unit type.
`define ISSUE_ALU_DEPTH 4
`define ISSUE_MEM_DEPTH 4
`define ISSUE_BRANCH_DEPTH 2
`define ISSUE_MULT_DEPTH 2

`endif

/* issue_pkg.sv */
`default_nettype none

`include "issue_params.svh"

package issue_pkg;

    // selects the target issue queue.
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        MEM    = 2'd1,
        BRANCH = 2'd2,
        MULT   = 2'd3
    } unit_type_t;

    // one operand word. value is valid when the operand is ready,
    // otherwise the low bits hold the producer tag.
    typedef union packed {
        logic [`ISSUE_DATA_W-1:0] value;
        struct packed {
            logic [`ISSUE_DATA_W-`ISSUE_TAG_W-1:0] pad;
            logic [`ISSUE_TAG_W-1:0]               tag;
        } pend;
    } operand_t;

endpackage

`default_nettype wire

/* issue_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_params.svh"

module issue_queue #(
    parameter int DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      wr_valid,
    input  wire                      wr_src1_ready,
    input  wire issue_pkg::operand_t wr_src1,
    input  wire                      wr_src2_ready,
    input  wire issue_pkg::operand_t wr_src2,
    input  wire [`ISSUE_TAG_W-1:0]   wr_dst,
    input  wire [`ISSUE_DATA_W-1:0]  wr_imm,
    input  wire [`ISSUE_CTL_W-1:0]   wr_ctl,
    input  wire                      wake_valid,
    input  wire [`ISSUE_TAG_W-1:0]   wake_tag,
    input  wire [`ISSUE_DATA_W-1:0]  wake_data,
    input  wire                      iss_ack,
    output logic                     full,
    output logic                     iss_req,
    output logic [`ISSUE_DATA_W-1:0] iss_src1,
    output logic [`ISSUE_DATA_W-1:0] iss_src2,
    output logic [`ISSUE_TAG_W-1:0]  iss_dst,
    output logic [`ISSUE_DATA_W-1:0] iss_imm,
    output logic [`ISSUE_CTL_W-1:0]  iss_ctl
);

    import issue_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry 0 is the oldest.
    logic [CNT_W-1:0]         count;
    logic [CNT_W-1:0]         count_n;
    logic                     rdy1_q [DEPTH];
    logic                     rdy2_q [DEPTH];
    operand_t                 src1_q [DEPTH];
    operand_t                 src2_q [DEPTH];
    logic [`ISSUE_TAG_W-1:0]  dst_q  [DEPTH];
    logic [`ISSUE_DATA_W-1:0] imm_q  [DEPTH];
    logic [`ISSUE_CTL_W-1:0]  ctl_q  [DEPTH];
    logic                     rdy1_n [DEPTH];
    logic                     rdy2_n [DEPTH];
    operand_t                 src1_n [DEPTH];
    operand_t                 src2_n [DEPTH];
    logic [`ISSUE_TAG_W-1:0]  dst_n  [DEPTH];
    logic [`ISSUE_DATA_W-1:0] imm_n  [DEPTH];
    logic [`ISSUE_CTL_W-1:0]  ctl_n  [DEPTH];

    logic                     ack_wait;
    logic [IDX_W-1:0]         sel_idx;
    logic                     found;
    logic [IDX_W-1:0]         pick;
    logic                     remove;

    assign full   = (count == CNT_W'(DEPTH));
    assign remove = iss_req && iss_ack;

    // oldest entry with both operands ready.
    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i < int'(count) && rdy1_q[i] && rdy2_q[i]) begin
                found = 1'b1;
                pick  = IDX_W'(i);
            end
        end
    end

    always_comb begin
        count_n = count;
        // wake capture.
        for (int i = 0; i < DEPTH; i++) begin
            rdy1_n[i] = rdy1_q[i];
            src1_n[i] = src1_q[i];
            rdy2_n[i] = rdy2_q[i];
            src2_n[i] = src2_q[i];
            dst_n[i]  = dst_q[i];
            imm_n[i]  = imm_q[i];
            ctl_n[i]  = ctl_q[i];
            if (wake_valid && !rdy1_q[i] && src1_q[i].pend.tag == wake_tag) begin
                rdy1_n[i]       = 1'b1;
                src1_n[i].value = wake_data;
            end
            if (wake_valid && !rdy2_q[i] && src2_q[i].pend.tag == wake_tag) begin
                rdy2_n[i]       = 1'b1;
                src2_n[i].value = wake_data;
            end
        end
        // compact over the issued slot to keep age order.
        if (remove) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                if (i >= int'(sel_idx)) begin
                    rdy1_n[i] = rdy1_n[i + 1];
                    src1_n[i] = src1_n[i + 1];
                    rdy2_n[i] = rdy2_n[i + 1];
                    src2_n[i] = src2_n[i + 1];
                    dst_n[i]  = dst_n[i + 1];
                    imm_n[i]  = imm_n[i + 1];
                    ctl_n[i]  = ctl_n[i + 1];
                end
            end
            count_n = count - 1'b1;
        end
        // append behind the youngest.
        if (wr_valid) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (i == int'(count_n)) begin
                    rdy1_n[i] = wr_src1_ready;
                    src1_n[i] = wr_src1;
                    rdy2_n[i] = wr_src2_ready;
                    src2_n[i] = wr_src2;
                    dst_n[i]  = wr_dst;
                    imm_n[i]  = wr_imm;
                    ctl_n[i]  = wr_ctl;
                end
            end
            count_n = count_n + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count_n;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            rdy1_q[i] <= rdy1_n[i];
            src1_q[i] <= src1_n[i];
            rdy2_q[i] <= rdy2_n[i];
            src2_q[i] <= src2_n[i];
            dst_q[i]  <= dst_n[i];
            imm_q[i]  <= imm_n[i];
            ctl_q[i]  <= ctl_n[i];
        end
    end

    // four-phase issue port.
    always_ff @(posedge clk) begin
        if (rst) begin
            iss_req  <= 1'b0;
            ack_wait <= 1'b0;
        end else if (iss_req) begin
            if (iss_ack) begin
                iss_req  <= 1'b0;
                ack_wait <= 1'b1;
            end
        end else if (ack_wait) begin
            if (!iss_ack) begin
                ack_wait <= 1'b0;
            end
        end else if (found) begin
            iss_req <= 1'b1;
        end
    end

    // payload is held while req is high.
    always_ff @(posedge clk) begin
        if (!iss_req && !ack_wait && found) begin
            sel_idx  <= pick;
            iss_src1 <= src1_q[pick].value;
            iss_src2 <= src2_q[pick].value;
            iss_dst  <= dst_q[pick];
            iss_imm  <= imm_q[pick];
            iss_ctl  <= ctl_q[pick];
        end
    end

endmodule

`default_nettype wire

/* issue_testdata.txt */
# D type dst src1 src2 imm ctl | W tag data | H/R unit | E unit src1 src2 dst imm ctl
# P type dst src1 src2 imm ctl cycles | A | B dispatch + wtag wdata | C cycles | S
# units: 0 alu 1 mem 2 branch 3 mult, all fields hex
E 0 0 0 01 00000011 a1
D 0 01 02 03 00000011 a1
E 1 0 0 02 00000022 b2
D 1 02 04 05 00000022 b2
E 2 0 0 03 00000033 c3
D 2 03 06 07 00000033 c3
E 3 0 0 04 00000044 d4
D 3 04 08 09 00000044 d4
S
W 04 1234abcd
W 05 00000055
E 0 1234abcd 00000055 0a 00000001 10
D 0 0a 04 05 00000001 10
S
E 3 0 0 0b 00000002 20
D 3 0b 00 00 00000002 20
E 0 cafef00d 1234abcd 0c 00000003 21
D 0 0c 0b 04 00000003 21
E 1 1234abcd 0 0d 00000004 22
D 1 0d 04 00 00000004 22
C 10
W 0b cafef00d
S
H 0
E 0 0 0 10 00000005 30
E 0 0 0 11 00000006 31
E 0 0 0 13 00000008 33
E 0 00000077 0 12 00000007 32
D 0 10 00 00 00000005 30
D 0 11 00 00 00000006 31
D 0 12 0c 00 00000007 32
D 0 13 00 00 00000008 33
R 0
C 14
W 0c 00000077
S
H 3
E 3 0 0 14 00000009 40
E 3 0 0 15 0000000a 41
E 3 0 0 16 0000000b 42
D 3 14 00 00 00000009 40
D 3 15 00 00 0000000a 41
P 3 16 00 00 0000000b 42 8
R 3
A
S
E 2 0 0 18 0000000d 51
D 2 18 00 00 0000000d 51
E 1 89abcdef 0 19 0000000e 52
B 1 19 18 00 0000000e 52 18 89abcdef
E 0 0 0 1a 0000000f 53
D 0 1a 1a 00 0000000f 53
S

/* operand_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_params.svh"

module operand_table (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      wake_valid,
    input  wire [`ISSUE_TAG_W-1:0]   wake_tag,
    input  wire [`ISSUE_DATA_W-1:0]  wake_data,
    input  wire [`ISSUE_TAG_W-1:0]   rd1_tag,
    input  wire [`ISSUE_TAG_W-1:0]   rd2_tag,
    input  wire                      alloc_valid,
    input  wire [`ISSUE_TAG_W-1:0]   alloc_tag,
    output logic                     rd1_ready,
    output logic [`ISSUE_DATA_W-1:0] rd1_value,
    output logic                     rd2_ready,
    output logic [`ISSUE_DATA_W-1:0] rd2_value
);

    logic [`ISSUE_DATA_W-1:0]  value_q [`ISSUE_PREG_NUM];
    logic [`ISSUE_PREG_NUM-1:0] ready_q;
    logic                      wake_hit1;
    logic                      wake_hit2;

    // a wake on the read tag this cycle is forwarded.
    assign wake_hit1 = wake_valid && (wake_tag == rd1_tag);
    assign wake_hit2 = wake_valid && (wake_tag == rd2_tag);

    assign rd1_ready = ready_q[rd1_tag] | wake_hit1;
    assign rd1_value = wake_hit1 ? wake_data : value_q[rd1_tag];
    assign rd2_ready = ready_q[rd2_tag] | wake_hit2;
    assign rd2_value = wake_hit2 ? wake_data : value_q[rd2_tag];

    // all registers come out of reset ready and zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ISSUE_PREG_NUM; i++) begin
                value_q[i] <= '0;
            end
        end else if (wake_valid) begin
            value_q[wake_tag] <= wake_data;
        end
    end

    // allocation wins over a wake to the same tag.
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '1;
        end else begin
            if (wake_valid) begin
                ready_q[wake_tag] <= 1'b1;
            end
            if (alloc_valid) begin
                ready_q[alloc_tag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f issue.f \
    --top-module tb_issue \
    -o tb_issue_sim

./obj_dir/tb_issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over five rising edges.
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "issue_params.svh"

module tb_issue;

    import issue_pkg::*;

    typedef struct packed {
        logic [`ISSUE_DATA_W-1:0] src1;
        logic [`ISSUE_DATA_W-1:0] src2;
        logic [`ISSUE_TAG_W-1:0]  dst;
        logic [`ISSUE_DATA_W-1:0] imm;
        logic [`ISSUE_CTL_W-1:0]  ctl;
    } issue_rec_t;

    wire                      clk;
    wire                      rst;
    logic                     disp_req;
    unit_type_t               disp_type;
    logic [`ISSUE_TAG_W-1:0]  disp_dst;
    logic [`ISSUE_TAG_W-1:0]  disp_src1;
    logic [`ISSUE_TAG_W-1:0]  disp_src2;
    logic [`ISSUE_DATA_W-1:0] disp_imm;
    logic [`ISSUE_CTL_W-1:0]  disp_ctl;
    logic                     disp_ack;
    logic                     wake_valid;
    logic [`ISSUE_TAG_W-1:0]  wake_tag;
    logic [`ISSUE_DATA_W-1:0] wake_data;
    logic [3:0]               req_w;
    logic [3:0]               ack_r;
    logic [3:0]               hold;
    logic [3:0]               seen;
    int                       wait_cnt [4];
    issue_rec_t               got_w [4];
    issue_rec_t               exp_q [4][$];
    int                       mismatch_cnt;
    int                       extra_cnt;
    int                       missing_cnt;
    int                       cycles;
    int                       limit;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    issue UUT (
        .clk, .rst, .disp_req, .disp_type, .disp_dst, .disp_src1, .disp_src2,
        .disp_imm, .disp_ctl, .disp_ack, .wake_valid, .wake_tag, .wake_data,
        .alu_req(req_w[0]), .alu_src1(got_w[0].src1), .alu_src2(got_w[0].src2),
        .alu_dst(got_w[0].dst), .alu_imm(got_w[0].imm), .alu_ctl(got_w[0].ctl),
        .alu_ack(ack_r[0]),
        .mem_req(req_w[1]), .mem_src1(got_w[1].src1), .mem_src2(got_w[1].src2),
        .mem_dst(got_w[1].dst), .mem_imm(got_w[1].imm), .mem_ctl(got_w[1].ctl),
        .mem_ack(ack_r[1]),
        .br_req(req_w[2]), .br_src1(got_w[2].src1), .br_src2(got_w[2].src2),
        .br_dst(got_w[2].dst), .br_imm(got_w[2].imm), .br_ctl(got_w[2].ctl),
        .br_ack(ack_r[2]),
        .mul_req(req_w[3]), .mul_src1(got_w[3].src1), .mul_src2(got_w[3].src2),
        .mul_dst(got_w[3].dst), .mul_imm(got_w[3].imm), .mul_ctl(got_w[3].ctl),
        .mul_ack(ack_r[3])
    );

    // run limit scales with the data file length.
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // execution unit side checks each issue and acks after a random delay.
    always @(negedge clk) begin
        if (!rst) begin
            for (int u = 0; u < 4; u++) begin
                if (ack_r[u]) begin
                    if (!req_w[u]) begin
                        ack_r[u] = 1'b0;
                    end
                end else if (req_w[u] && !hold[u]) begin
                    if (!seen[u]) begin
                        seen[u] = 1'b1;
                        wait_cnt[u] = $urandom_range(3, 0);
                        compare_issue(u);
                    end
                    if (wait_cnt[u] == 0) begin
                        ack_r[u] = 1'b1;
                        seen[u] = 1'b0;
                    end else begin
                        wait_cnt[u]--;
                    end
                end
            end
        end
    end

    task automatic compare_issue(input int u);
        issue_rec_t want;
        if (exp_q[u].size() == 0) begin
            $display("unit %0d issued an instruction that no record expects", u);
            extra_cnt++;
        end else begin
            want = exp_q[u].pop_front();
            assert (got_w[u] == want) else begin
                $display("ERR %0t: unit %0d issued %h, expected %h",
                         $time, u, got_w[u], want);
                mismatch_cnt++;
            end
        end
    endtask

    task automatic start_dispatch(input logic [31:0] t, input logic [31:0] dst,
                                  input logic [31:0] s1, input logic [31:0] s2,
                                  input logic [31:0] imm, input logic [31:0] ctl);
        disp_type = unit_type_t'(t[1:0]);
        disp_dst  = dst[`ISSUE_TAG_W-1:0];
        disp_src1 = s1[`ISSUE_TAG_W-1:0];
        disp_src2 = s2[`ISSUE_TAG_W-1:0];
        disp_imm  = imm;
        disp_ctl  = ctl[`ISSUE_CTL_W-1:0];
        disp_req  = 1'b1;
    endtask

    // wait for ack, drop req, wait for ack low.
    task automatic finish_dispatch();
        while (!disp_ack) @(negedge clk);
        disp_req = 1'b0;
        while (disp_ack) @(negedge clk);
    endtask

    task automatic send_wake(input logic [31:0] tag, input logic [31:0] data);
        wake_valid = 1'b1;
        wake_tag   = tag[`ISSUE_TAG_W-1:0];
        wake_data  = data;
        @(negedge clk);
        wake_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0
               || req_w != 4'b0000) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int         fd;
        int         nlines;
        string      cmd;
        string      line;
        logic [31:0] a, b, c, d, e, f, g, h;
        issue_rec_t rec;

        disp_req     = 1'b0;
        disp_type    = ALU;
        disp_dst     = '0;
        disp_src1    = '0;
        disp_src2    = '0;
        disp_imm     = '0;
        disp_ctl     = '0;
        wake_valid   = 1'b0;
        wake_tag     = '0;
        wake_data    = '0;
        ack_r        = 4'b0000;
        hold         = 4'b0000;
        seen         = 4'b0000;
        mismatch_cnt = 0;
        extra_cnt    = 0;
        missing_cnt  = 0;
        cycles       = 0;
        limit        = 0;
        for (int u = 0; u < 4; u++) begin
            wait_cnt[u] = 0;
        end
        void'($urandom(32'h7f5c));

        fd = $fopen("issue_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open issue_testdata.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            nlines = 0;
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                nlines++;
            end
            $fclose(fd);
            limit = 40 * nlines;

            @(negedge clk);
            while (rst) @(negedge clk);
            // outputs idle after reset.
            assert (disp_ack == 1'b0 && req_w == 4'b0000) else begin
                $display("ERR %0t: handshake outputs not low after reset", $time);
                mismatch_cnt++;
            end

            fd = $fopen("issue_testdata.txt", "r");
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd.substr(0, 0) == "#") begin
                    void'($fgets(line, fd));
                end else if (cmd == "D") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f));
                    start_dispatch(a, b, c, d, e, f);
                    finish_dispatch();
                end else if (cmd == "P") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h %h", a, b, c, d, e, f, g));
                    start_dispatch(a, b, c, d, e, f);
                    repeat (g) begin
                        @(negedge clk);
                        assert (!disp_ack) else begin
                            $display("ERR %0t: dispatch acknowledged into a full queue", $time);
                            mismatch_cnt++;
                        end
                    end
                end else if (cmd == "A") begin
                    finish_dispatch();
                end else if (cmd == "B") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h %h %h", a, b, c, d, e, f, g, h));
                    start_dispatch(a, b, c, d, e, f);
                    send_wake(g, h);
                    finish_dispatch();
                end else if (cmd == "W") begin
                    void'($fscanf(fd, "%h %h", a, b));
                    send_wake(a, b);
                end else if (cmd == "H") begin
                    void'($fscanf(fd, "%h", a));
                    hold[a[1:0]] = 1'b1;
                end else if (cmd == "R") begin
                    void'($fscanf(fd, "%h", a));
                    hold[a[1:0]] = 1'b0;
                end else if (cmd == "E") begin
                    void'($fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f));
                    rec.src1 = b;
                    rec.src2 = c;
                    rec.dst  = d[`ISSUE_TAG_W-1:0];
                    rec.imm  = e;
                    rec.ctl  = f[`ISSUE_CTL_W-1:0];
                    exp_q[a[1:0]].push_back(rec);
                end else if (cmd == "C") begin
                    void'($fscanf(fd, "%h", a));
                    repeat (a) @(negedge clk);
                end else if (cmd == "S") begin
                    wait_drained();
                end else begin
                    $display("unknown command %s in the data file", cmd);
                    extra_cnt++;
                end
            end
            $fclose(fd);
            repeat (10) @(negedge clk);

            for (int u = 0; u < 4; u++) begin
                missing_cnt += exp_q[u].size();
            end
            $display("errors: %0d mismatches, %0d unexpected issues, %0d missing issues",
                     mismatch_cnt, extra_cnt, missing_cnt);
            if (mismatch_cnt + extra_cnt + missing_cnt == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
